// ==== hw/anneal_top.sv ====
module anneal_top
    import replica_pkg::*;
(
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         load,
    input  logic [DATA_W-1:0]            load_data,
    input  logic                         step,
    input  logic [N_REPLICA*DELTA_W-1:0] delta_in,
    input  logic [N_REPLICA*CMD_W-1:0]   move_cmd_in,
    input  logic [N_REPLICA*IDX_W-1:0]   move_k_in,
    input  logic [N_REPLICA*IDX_W-1:0]   move_l_in,
    input  logic                         exchange,
    output logic [N_REPLICA*DATA_W-1:0]  lengths,
    output logic [N_REPLICA*CMD_W-1:0]   move_cmd_out,
    output logic [N_REPLICA*IDX_W-1:0]   move_k_out,
    output logic [N_REPLICA*IDX_W-1:0]   move_l_out,
    output logic                         step_done
);

    logic [N_REPLICA*XCH_W-1:0] xch_flat;

    replica_chain u_chain (
        .clk          (clk),
        .reset        (reset),
        .load         (load),
        .load_data    (load_data),
        .step         (step),
        .delta_in     (delta_in),
        .move_cmd_in  (move_cmd_in),
        .move_k_in    (move_k_in),
        .move_l_in    (move_l_in),
        .xch_flat     (xch_flat),
        .data_flat    (lengths),
        .move_cmd_out (move_cmd_out),
        .move_k_out   (move_k_out),
        .move_l_out   (move_l_out),
        .step_done    (step_done)
    );

    exchange_control u_exchange (
        .clk       (clk),
        .reset     (reset),
        .exchange  (exchange),
        .data_flat (lengths),
        .xch_flat  (xch_flat)
    );

    a_strobes_exclusive: assert property (
        @(posedge clk) disable iff (reset) $onehot0({load, step, exchange})
    );

    // a load or swap on the stage-two edge would override the step result.
    a_no_write_collision: assert property (
        @(posedge clk) disable iff (reset) step |=> !(load || exchange)
    );

endmodule

// ==== hw/boltzmann_exp.sv ====
module boltzmann_exp
    import replica_pkg::*;
#(
    parameter int nbeta = DBETA
)
(
    input  logic               clk,
    input  logic               reset,
    input  logic [DELTA_W-1:0] x,
    input  logic               run,
    output logic [PROB_W-1:0]  y
);

    localparam int           PROD_W = DELTA_W + 32;
    localparam logic [31:0]  NBETA  = nbeta;
    localparam logic [PROB_W-1:0] ONE = {1'b1, {(PROB_W-1){1'b0}}};

    logic [PROD_W-1:0]   prod;
    logic [PROD_W-9:0]   expo;
    logic [PROB_W-1:0]   approx;

    // exp(-x * beta) taken as 2^-(x * beta / 256).
    assign prod = {32'd0, x} * {{DELTA_W{1'b0}}, NBETA};
    assign expo = prod[PROD_W-1:8];

    always_comb begin
        if (expo >= PROD_W'(PROB_W)) begin
            approx = '0;
        end else begin
            approx = ONE >> expo[4:0];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            y <= '0;
        end else if (run) begin
            y <= approx;
        end
    end

endmodule

// ==== hw/exchange_control.sv ====
module exchange_control
    import replica_pkg::*;
(
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        exchange,
    input  logic [N_REPLICA*DATA_W-1:0] data_flat,
    output logic [N_REPLICA*XCH_W-1:0]  xch_flat
);

    // 0 selects pairs (0,1),(2,3); 1 selects (1,2).
    logic parity;

    always_ff @(posedge clk) begin
        if (reset) begin
            parity <= 1'b0;
        end else if (exchange) begin
            parity <= ~parity;
        end
    end

    // pairs of one parity never overlap, so each replica sees at most one swap.
    always_comb begin
        logic [DATA_W-1:0] warm;
        logic [DATA_W-1:0] cold;

        xch_flat = {N_REPLICA{XCH_HOLD}};
        warm     = '0;
        cold     = '0;
        if (exchange) begin
            for (int i = 0; i < N_REPLICA - 1; i++) begin
                warm = data_flat[i*DATA_W +: DATA_W];
                cold = data_flat[(i+1)*DATA_W +: DATA_W];
                if ((i % 2) == int'(parity) && cold > warm) begin
                    xch_flat[i*XCH_W +: XCH_W]     = XCH_FOLW;
                    xch_flat[(i+1)*XCH_W +: XCH_W] = XCH_PREV;
                end
            end
        end
    end

endmodule

// ==== hw/lfsr_random.sv ====
module lfsr_random
    import replica_pkg::*;
#(
    parameter logic [31:0] seed = LFSR_SEED_BASE
)
(
    input  logic        clk,
    input  logic        reset,
    input  logic        advance,
    output logic [31:0] rand_word
);

    logic [31:0] state;
    logic [31:0] next_state;

    // right-shifting galois form, feedback taken from bit 0.
    assign next_state = {1'b0, state[31:1]} ^ (state[0] ? LFSR_POLY : 32'd0);
    assign rand_word  = state;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= seed;
        end else if (advance) begin
            state <= next_state;
        end
    end

    // the all-zero state would lock the generator.
    a_state_nonzero: assert property (
        @(posedge clk) disable iff (reset) state != 32'd0
    );

endmodule

// ==== hw/metropolis.sv ====
module metropolis
    import replica_pkg::*;
#(
    parameter int id = 0
)
(
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      step,
    input  logic                      load,
    input  logic signed [DELTA_W-1:0] delta,
    input  logic [31:0]               rand_word,
    input  logic [CMD_W-1:0]          in_cmd,
    input  logic [IDX_W-1:0]          in_k,
    input  logic [IDX_W-1:0]          in_l,
    input  logic [XCH_W-1:0]          xch_cmd,
    input  logic [DATA_W-1:0]         prev_data,
    input  logic [DATA_W-1:0]         folw_data,
    output logic [DATA_W-1:0]         out_data,
    output logic [CMD_W-1:0]          out_cmd,
    output logic [IDX_W-1:0]          out_k,
    output logic [IDX_W-1:0]          out_l,
    output logic                      done
);

    logic [DELTA_W-1:0]        uphill;
    logic [PROB_W-1:0]         thresh;

    logic                      s1_valid;
    logic signed [DELTA_W-1:0] s1_delta;
    logic [PROB_W-1:0]         s1_rand;
    logic [CMD_W-1:0]          s1_cmd;
    logic [IDX_W-1:0]          s1_k;
    logic [IDX_W-1:0]          s1_l;

    logic                      accept;
    logic signed [DATA_W+1:0]  sum;

    // only an uphill move needs the threshold; downhill moves pass anyway.
    assign uphill = (delta > 0) ? $unsigned(delta) : '0;

    boltzmann_exp #(
        .nbeta (DBETA * (id + 1))
    ) u_exp (
        .clk   (clk),
        .reset (reset),
        .x     (uphill),
        .run   (step),
        .y     (thresh)
    );

    // stage one, lined up with the registered threshold.
    always_ff @(posedge clk) begin
        if (reset) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= step;
        end
    end

    always_ff @(posedge clk) begin
        if (step) begin
            s1_delta <= delta;
            s1_rand  <= rand_word[PROB_W-1:0];
            s1_cmd   <= in_cmd;
            s1_k     <= in_k;
            s1_l     <= in_l;
        end
    end

    // stage two.
    assign accept = (s1_delta <= 0) || (thresh > s1_rand);
    assign sum    = $signed({2'b00, out_data}) + s1_delta;

    always_ff @(posedge clk) begin
        if (reset) begin
            out_data <= '0;
        end else if (load) begin
            out_data <= prev_data;
        end else if (xch_cmd == XCH_PREV) begin
            out_data <= prev_data;
        end else if (xch_cmd == XCH_FOLW) begin
            out_data <= folw_data;
        end else if (s1_valid && accept) begin
            out_data <= sum[DATA_W-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            out_cmd <= CMD_NONE;
            done    <= 1'b0;
        end else begin
            done <= s1_valid;
            if (s1_valid) begin
                if (s1_cmd == CMD_THR || !accept) begin
                    out_cmd <= CMD_THR;
                end else if (s1_cmd == CMD_TWO) begin
                    out_cmd <= CMD_TWO;
                end else begin
                    out_cmd <= (s1_k < s1_l) ? CMD_OR0 : CMD_OR1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (s1_valid) begin
            out_k <= s1_k;
            out_l <= s1_l;
        end
    end

    // a tour cannot get shorter than zero.
    a_no_underflow: assert property (
        @(posedge clk) disable iff (reset) (s1_valid && accept) |-> (sum >= 0)
    );

endmodule

// ==== hw/replica_chain.sv ====
module replica_chain
    import replica_pkg::*;
(
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         load,
    input  logic [DATA_W-1:0]            load_data,
    input  logic                         step,
    input  logic [N_REPLICA*DELTA_W-1:0] delta_in,
    input  logic [N_REPLICA*CMD_W-1:0]   move_cmd_in,
    input  logic [N_REPLICA*IDX_W-1:0]   move_k_in,
    input  logic [N_REPLICA*IDX_W-1:0]   move_l_in,
    input  logic [N_REPLICA*XCH_W-1:0]   xch_flat,
    output logic [N_REPLICA*DATA_W-1:0]  data_flat,
    output logic [N_REPLICA*CMD_W-1:0]   move_cmd_out,
    output logic [N_REPLICA*IDX_W-1:0]   move_k_out,
    output logic [N_REPLICA*IDX_W-1:0]   move_l_out,
    output logic                         step_done
);

    logic [DATA_W-1:0]    len    [N_REPLICA];
    logic [N_REPLICA-1:0] done_vec;

    for (genvar i = 0; i < N_REPLICA; i++) begin : g_replica
        logic [31:0]       rand_word;
        logic [DATA_W-1:0] prev_data;
        logic [DATA_W-1:0] folw_data;

        // bottom of the chain is fed by the load port.
        assign prev_data = (i == 0) ? load_data : len[(i == 0) ? 0 : i - 1];
        // the top replica has no upper neighbour and sees itself.
        assign folw_data = len[(i == N_REPLICA - 1) ? i : i + 1];

        lfsr_random #(
            .seed (LFSR_SEED_BASE + 32'(i))
        ) u_lfsr (
            .clk       (clk),
            .reset     (reset),
            .advance   (step),
            .rand_word (rand_word)
        );

        metropolis #(
            .id (i)
        ) u_metropolis (
            .clk       (clk),
            .reset     (reset),
            .step      (step),
            .load      (load),
            .delta     ($signed(delta_in[i*DELTA_W +: DELTA_W])),
            .rand_word (rand_word),
            .in_cmd    (move_cmd_in[i*CMD_W +: CMD_W]),
            .in_k      (move_k_in[i*IDX_W +: IDX_W]),
            .in_l      (move_l_in[i*IDX_W +: IDX_W]),
            .xch_cmd   (xch_flat[i*XCH_W +: XCH_W]),
            .prev_data (prev_data),
            .folw_data (folw_data),
            .out_data  (len[i]),
            .out_cmd   (move_cmd_out[i*CMD_W +: CMD_W]),
            .out_k     (move_k_out[i*IDX_W +: IDX_W]),
            .out_l     (move_l_out[i*IDX_W +: IDX_W]),
            .done      (done_vec[i])
        );

        assign data_flat[i*DATA_W +: DATA_W] = len[i];
    end

    assign step_done = done_vec[0];

endmodule

// ==== hw/replica_pkg.sv ====
package replica_pkg;

    // chain size and data widths.
    localparam int N_REPLICA = 4;
    localparam int DATA_W    = 24;
    localparam int DELTA_W   = 16;
    localparam int IDX_W     = 8;

    // move commands.
    localparam int CMD_W = 3;

    localparam logic [CMD_W-1:0] CMD_NONE = 3'd0;
    localparam logic [CMD_W-1:0] CMD_OR0  = 3'd1;
    localparam logic [CMD_W-1:0] CMD_OR1  = 3'd2;
    localparam logic [CMD_W-1:0] CMD_TWO  = 3'd3;
    // sticky once set.
    localparam logic [CMD_W-1:0] CMD_THR  = 3'd4;

    // exchange commands, one per replica.
    localparam int XCH_W = 2;

    localparam logic [XCH_W-1:0] XCH_HOLD = 2'd0;
    localparam logic [XCH_W-1:0] XCH_PREV = 2'd1;
    localparam logic [XCH_W-1:0] XCH_FOLW = 2'd2;

    // replica i runs at beta = DBETA * (i + 1) / 256.
    localparam int DBETA = 32;

    // threshold width, compared against the low bits of the random word.
    localparam int PROB_W = 23;

    // galois feedback mask and seeds.
    localparam logic [31:0] LFSR_POLY      = 32'h8020_0003;
    localparam logic [31:0] LFSR_SEED_BASE = 32'h1f2e_3d4c;

endpackage

// ==== run.sh ====
#!/usr/bin/env bash
# Build the testbench with Verilator and run it; the exit status is the result.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_anneal \
    -f tb.f \
    -o tb_anneal_sim

./obj_dir/tb_anneal_sim

// ==== tb.f ====
hw/replica_pkg.sv
hw/boltzmann_exp.sv
hw/lfsr_random.sv
hw/metropolis.sv
hw/exchange_control.sv
hw/replica_chain.sv
hw/anneal_top.sv
tests/tb_anneal.sv

// ==== tests/tb_anneal.sv ====
module tb_anneal
    import replica_pkg::*;
();

    localparam int N_LOAD   = 4;
    localparam int N_DOWN   = 8;
    localparam int N_UP     = 32;
    localparam int N_BURST  = 16;
    localparam int N_XROUND = 5;
    localparam int N_XCH    = 3;

    localparam int STIM_CYCLES = 2 + (N_LOAD + 2) + 3 * N_DOWN + 3 * N_UP + (N_BURST + 2)
                               + N_XROUND * (N_LOAD + N_XCH + 1) + 4;
    localparam int WATCHDOG_CYCLES = STIM_CYCLES + 20;

    logic                         clk;
    logic                         reset;
    logic                         load;
    logic [DATA_W-1:0]            load_data;
    logic                         step;
    logic [N_REPLICA*DELTA_W-1:0] delta_in;
    logic [N_REPLICA*CMD_W-1:0]   move_cmd_in;
    logic [N_REPLICA*IDX_W-1:0]   move_k_in;
    logic [N_REPLICA*IDX_W-1:0]   move_l_in;
    logic                         exchange;
    logic [N_REPLICA*DATA_W-1:0]  lengths;
    logic [N_REPLICA*CMD_W-1:0]   move_cmd_out;
    logic [N_REPLICA*IDX_W-1:0]   move_k_out;
    logic [N_REPLICA*IDX_W-1:0]   move_l_out;
    logic                         step_done;

    int cycle_count = 0;

    // reference state of the chain.
    logic [DATA_W-1:0] model_len  [N_REPLICA];
    logic [CMD_W-1:0]  model_cmd  [N_REPLICA];
    logic [IDX_W-1:0]  model_k    [N_REPLICA];
    logic [IDX_W-1:0]  model_l    [N_REPLICA];
    logic [31:0]       model_lfsr [N_REPLICA];
    logic              model_parity;

    // expected results, in the order they become due.
    int                          exp_due   [$];
    bit                          exp_moves [$];
    logic [N_REPLICA*DATA_W-1:0] exp_len_q [$];
    logic [N_REPLICA*CMD_W-1:0]  exp_cmd_q [$];
    logic [N_REPLICA*IDX_W-1:0]  exp_k_q   [$];
    logic [N_REPLICA*IDX_W-1:0]  exp_l_q   [$];

    anneal_top u_anneal_top (
        .clk          (clk),
        .reset        (reset),
        .load         (load),
        .load_data    (load_data),
        .step         (step),
        .delta_in     (delta_in),
        .move_cmd_in  (move_cmd_in),
        .move_k_in    (move_k_in),
        .move_l_in    (move_l_in),
        .exchange     (exchange),
        .lengths      (lengths),
        .move_cmd_out (move_cmd_out),
        .move_k_out   (move_k_out),
        .move_l_out   (move_l_out),
        .step_done    (step_done)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    task automatic fail_run(input string why);
        $display("tests failed");
        $fatal(1, "%s", why);
    endtask

    function automatic logic [31:0] lfsr_advance(input logic [31:0] state);
        logic [31:0] shifted;
        shifted = state >> 1;
        if (state[0]) begin
            return shifted ^ LFSR_POLY;
        end else begin
            return shifted;
        end
    endfunction

    // 2^22 scaled down by 2^(delta * beta / 256).
    function automatic logic [PROB_W-1:0] boltzmann_threshold(
        input int r,
        input logic signed [DELTA_W-1:0] delta
    );
        longint expo;
        longint top;
        expo = (longint'(delta) * longint'(DBETA * (r + 1))) >>> 8;
        top  = longint'(1) << (PROB_W - 1);
        if (expo >= longint'(PROB_W)) begin
            return '0;
        end else begin
            return PROB_W'(top >>> expo);
        end
    endfunction

    // updates the model length on accept and returns the new command.
    function automatic logic [CMD_W-1:0] apply_move(
        input int                        r,
        input logic signed [DELTA_W-1:0] delta,
        input logic [31:0]               rnd,
        input logic [CMD_W-1:0]          cmd,
        input logic [IDX_W-1:0]          k,
        input logic [IDX_W-1:0]          l
    );
        logic accept;
        if (delta <= 0) begin
            accept = 1'b1;
        end else begin
            accept = boltzmann_threshold(r, delta) > rnd[PROB_W-1:0];
        end
        if (accept) begin
            model_len[r] = DATA_W'(int'(model_len[r]) + int'(delta));
        end
        if (cmd == CMD_THR || !accept) begin
            return CMD_THR;
        end else if (cmd == CMD_TWO) begin
            return CMD_TWO;
        end else if (k < l) begin
            return CMD_OR0;
        end else begin
            return CMD_OR1;
        end
    endfunction

    function automatic void apply_exchange();
        logic [DATA_W-1:0] held;
        for (int i = 0; i < N_REPLICA - 1; i++) begin
            if ((i % 2) == int'(model_parity) && model_len[i+1] > model_len[i]) begin
                held           = model_len[i];
                model_len[i]   = model_len[i+1];
                model_len[i+1] = held;
            end
        end
        model_parity = ~model_parity;
    endfunction

    function automatic logic [CMD_W-1:0] pick_cmd(input bit allow_thr);
        int sel;
        sel = int'($urandom_range(allow_thr ? 4 : 3, 0));
        case (sel)
            0:       return CMD_NONE;
            1:       return CMD_OR0;
            2:       return CMD_OR1;
            3:       return CMD_TWO;
            default: return CMD_THR;
        endcase
    endfunction

    task automatic check_lengths(
        input logic [N_REPLICA*DATA_W-1:0] got,
        input logic [N_REPLICA*DATA_W-1:0] want
    );
        if (got !== want) begin
            $display("Mismatch at time %0t: lengths %h, expected %h", $time, got, want);
            fail_run("length check failed");
        end
    endtask

    task automatic check_moves(
        input logic [N_REPLICA*CMD_W-1:0] got_cmd,
        input logic [N_REPLICA*CMD_W-1:0] want_cmd,
        input logic [N_REPLICA*IDX_W-1:0] got_k,
        input logic [N_REPLICA*IDX_W-1:0] want_k,
        input logic [N_REPLICA*IDX_W-1:0] got_l,
        input logic [N_REPLICA*IDX_W-1:0] want_l,
        input bit                         with_idx
    );
        if (got_cmd !== want_cmd) begin
            $display("Mismatch at time %0t: commands %h, expected %h", $time, got_cmd, want_cmd);
            fail_run("move command check failed");
        end else if (with_idx && (got_k !== want_k || got_l !== want_l)) begin
            $display("Mismatch at time %0t: k %h l %h, expected k %h l %h",
                     $time, got_k, got_l, want_k, want_l);
            fail_run("cut index check failed");
        end
    endtask

    task automatic check_done(input logic got, input logic want);
        if (got !== want) begin
            $display("Mismatch at time %0t: step_done %b, expected %b", $time, got, want);
            fail_run("step_done check failed");
        end
    endtask

    task automatic push_expect(input int due, input bit with_moves);
        logic [N_REPLICA*DATA_W-1:0] len_v;
        logic [N_REPLICA*CMD_W-1:0]  cmd_v;
        logic [N_REPLICA*IDX_W-1:0]  k_v;
        logic [N_REPLICA*IDX_W-1:0]  l_v;
        for (int r = 0; r < N_REPLICA; r++) begin
            len_v[r*DATA_W +: DATA_W] = model_len[r];
            cmd_v[r*CMD_W +: CMD_W]   = model_cmd[r];
            k_v[r*IDX_W +: IDX_W]     = model_k[r];
            l_v[r*IDX_W +: IDX_W]     = model_l[r];
        end
        exp_due.push_back(due);
        exp_moves.push_back(with_moves);
        exp_len_q.push_back(len_v);
        exp_cmd_q.push_back(cmd_v);
        exp_k_q.push_back(k_v);
        exp_l_q.push_back(l_v);
    endtask

    // outputs have settled a few units after the edge.
    always @(posedge clk) begin
        #5;
        if (exp_due.size() != 0 && exp_due[0] <= cycle_count) begin
            if (exp_due[0] != cycle_count) begin
                fail_run("an expected result passed its due cycle unchecked");
            end else begin
                check_lengths(lengths, exp_len_q[0]);
                check_done(step_done, exp_moves[0]);
                check_moves(move_cmd_out, exp_cmd_q[0], move_k_out, exp_k_q[0],
                            move_l_out, exp_l_q[0], exp_moves[0]);
                void'(exp_due.pop_front());
                void'(exp_moves.pop_front());
                void'(exp_len_q.pop_front());
                void'(exp_cmd_q.pop_front());
                void'(exp_k_q.pop_front());
                void'(exp_l_q.pop_front());
            end
        end
    end

    // strobes last one cycle unless the caller raises them again.
    task automatic next_slot();
        @(posedge clk);
        #10;
        load     = 1'b0;
        step     = 1'b0;
        exchange = 1'b0;
    endtask

    task automatic idle(input int n);
        repeat (n) next_slot();
    endtask

    task automatic issue_load(input logic [DATA_W-1:0] value);
        next_slot();
        load      = 1'b1;
        load_data = value;
        for (int r = N_REPLICA - 1; r > 0; r--) begin
            model_len[r] = model_len[r-1];
        end
        model_len[0] = value;
        push_expect(cycle_count + 1, 1'b0);
    endtask

    task automatic issue_exchange();
        next_slot();
        exchange = 1'b1;
        apply_exchange();
        push_expect(cycle_count + 1, 1'b0);
    endtask

    task automatic issue_step(
        input logic [N_REPLICA*DELTA_W-1:0] deltas,
        input logic [N_REPLICA*CMD_W-1:0]   cmds,
        input logic [N_REPLICA*IDX_W-1:0]   ks,
        input logic [N_REPLICA*IDX_W-1:0]   ls
    );
        logic signed [DELTA_W-1:0] d;
        next_slot();
        step        = 1'b1;
        delta_in    = deltas;
        move_cmd_in = cmds;
        move_k_in   = ks;
        move_l_in   = ls;
        for (int r = 0; r < N_REPLICA; r++) begin
            d            = $signed(deltas[r*DELTA_W +: DELTA_W]);
            model_cmd[r] = apply_move(r, d, model_lfsr[r], cmds[r*CMD_W +: CMD_W],
                                      ks[r*IDX_W +: IDX_W], ls[r*IDX_W +: IDX_W]);
            model_k[r]    = ks[r*IDX_W +: IDX_W];
            model_l[r]    = ls[r*IDX_W +: IDX_W];
            model_lfsr[r] = lfsr_advance(model_lfsr[r]);
        end
        push_expect(cycle_count + 2, 1'b1);
    endtask

    task automatic random_step(input int lo, input int hi, input bit allow_thr);
        logic [N_REPLICA*DELTA_W-1:0] deltas;
        logic [N_REPLICA*CMD_W-1:0]   cmds;
        logic [N_REPLICA*IDX_W-1:0]   ks;
        logic [N_REPLICA*IDX_W-1:0]   ls;
        int                           d;
        for (int r = 0; r < N_REPLICA; r++) begin
            d = lo + int'($urandom_range(32'(hi - lo), 0));
            deltas[r*DELTA_W +: DELTA_W] = DELTA_W'(d);
            cmds[r*CMD_W +: CMD_W]       = pick_cmd(allow_thr);
            ks[r*IDX_W +: IDX_W]         = IDX_W'($urandom_range(255, 0));
            ls[r*IDX_W +: IDX_W]         = IDX_W'($urandom_range(255, 0));
        end
        issue_step(deltas, cmds, ks, ls);
    endtask

    initial begin
        #(WATCHDOG_CYCLES * 100);
        fail_run("watchdog timeout, the run did not finish in time");
    end

    initial begin
        void'($urandom(32'hf36d));
        clk         = 1'b0;
        reset       = 1'b1;
        load        = 1'b0;
        load_data   = '0;
        step        = 1'b0;
        delta_in    = '0;
        move_cmd_in = '0;
        move_k_in   = '0;
        move_l_in   = '0;
        exchange    = 1'b0;
        for (int r = 0; r < N_REPLICA; r++) begin
            model_len[r]  = '0;
            model_cmd[r]  = CMD_NONE;
            model_k[r]    = '0;
            model_l[r]    = '0;
            model_lfsr[r] = LFSR_SEED_BASE + 32'(r);
        end
        model_parity = 1'b0;

        repeat (2) @(posedge clk);
        #10;
        reset = 1'b0;
        check_lengths(lengths, '0);
        check_moves(move_cmd_out, {N_REPLICA{CMD_NONE}}, move_k_out, '0,
                    move_l_out, '0, 1'b0);
        check_done(step_done, 1'b0);

        for (int i = 0; i < N_LOAD; i++) begin
            issue_load(DATA_W'($urandom_range(800000, 200000)));
        end
        idle(2);

        // downhill moves, always accepted.
        for (int i = 0; i < N_DOWN; i++) begin
            random_step(-400, 0, 1'b0);
            idle(2);
        end

        // uphill moves decided by threshold and lfsr.
        for (int i = 0; i < N_UP; i++) begin
            random_step(1, 100, 1'b1);
            idle(2);
        end

        // two evaluations in flight.
        for (int i = 0; i < N_BURST; i++) begin
            random_step(-200, 100, 1'b1);
        end
        idle(2);

        for (int i = 0; i < N_XROUND; i++) begin
            for (int j = 0; j < N_LOAD; j++) begin
                issue_load(DATA_W'($urandom_range(900000, 100000)));
            end
            for (int j = 0; j < N_XCH; j++) begin
                issue_exchange();
            end
            idle(1);
        end

        idle(4);
        if (exp_due.size() == 0) begin
            $display("all tests passed");
            $finish;
        end else begin
            fail_run("expected results still pending at end of run");
        end
    end

endmodule
